// File: hdl/bubl_consts.svh
// Bus widths, ROM banking constants and idle read value for the main CPU glue
`ifndef BUBL_CONSTS_SVH
`define BUBL_CONSTS_SVH

////////////////////////////////////////////////////////////
// Widths

`define BUBL_AW       16    // Z80 address bus
`define BUBL_DW       8     // Data bus
`define BUBL_ROM_AW   18    // Main ROM space after banking
`define BUBL_WORK_AW  13    // 8 KB work RAM

////////////////////////////////////////////////////////////
// Memory map values

// Undecoded space floats high on the board
`define BUBL_IDLE_BYTE  8'hFF

// Bank number is offset past the two fixed 16 KB pages
`define BUBL_BANK_BASE  2

// Bubble Bobble wires the top bank bit inverted
`define BUBL_BUBBLE_BANK_XOR  4

`endif

// File: hdl/bubl_pkg.sv
// Read-source enum and ROM bank type shared by the main CPU glue
`default_nettype none

package bubl_pkg;

    // Which block answers the current CPU access
    typedef enum logic [7:0] {
        SRC_NONE  = 8'd0,   // Undecoded, reads idle byte
        SRC_ROM   = 8'd1,
        SRC_VRAM  = 8'd2,
        SRC_PAL   = 8'd3,
        SRC_WORK  = 8'd4,   // Main work RAM
        SRC_SOUND = 8'd5,   // Sound CPU latch and flags
        SRC_CAB   = 8'd6    // Tokio cabinet port
    } rd_src_t;

    // Banked window page number
    typedef logic [2:0] bank_t;

endpackage

`default_nettype wire

// File: hdl/bubl_main_decode.sv
// Main CPU address decoder for the Bubble Bobble and Tokio memory maps
`timescale 1ns/1ps
`default_nettype none
`include "bubl_consts.svh"

module bubl_main_decode (
    input  wire                  tokio,
    input  wire [`BUBL_AW-1:0]   cpu_addr,
    input  wire                  mreq_n,
    input  wire                  rd_n,
    input  wire                  wr_n,
    output bubl_pkg::rd_src_t    rd_src,
    output logic                 vram_cs,
    output logic                 pal_cs,
    output logic                 main_rom_cs,
    output logic                 misc_we,
    output logic                 flip_we,
    output logic                 snd_wr,
    output logic                 snd_rd
);

logic mem_rd, mem_wr;
logic rom_hit, vram_hit, work_hit, pal_hit;
logic snd_hit, misc_hit, flip_hit, cab_hit;

assign mem_rd = !mreq_n && !rd_n;
assign mem_wr = !mreq_n && !wr_n;

////////////////////////////////////////////////////////////
// Regions common to both games

assign rom_hit  = cpu_addr[15:14] != 2'b11;     // 0000-BFFF
assign vram_hit = cpu_addr[15:13] == 3'b110;    // C000-DFFF
assign work_hit = cpu_addr[15:13] == 3'b111 && cpu_addr[12:11] != 2'b11; // E000-F7FF
assign pal_hit  = cpu_addr[15:9] == 7'b1111_100;    // F800-F9FF

// Game specific I/O page
always_comb begin
    snd_hit  = 1'b0;
    misc_hit = 1'b0;
    flip_hit = 1'b0;
    cab_hit  = 1'b0;
    if (tokio) begin
        snd_hit  = cpu_addr[15:7] == 9'b1111_1100_0;    // FC00-FC7F
        misc_hit = cpu_addr[15:7] == 9'b1111_1010_1;    // FA80-FAFF
        flip_hit = cpu_addr[15:7] == 9'b1111_1011_0;    // FB00-FB7F
        cab_hit  = cpu_addr[15:7] == 9'b1111_1010_0;    // FA00-FA7F
    end else begin
        snd_hit  = cpu_addr[15:7] == 9'b1111_1010_0;    // FA00-FA7F
        misc_hit = cpu_addr[15:6] == 10'b1111_1011_01;  // FB40-FB7F
    end
end

////////////////////////////////////////////////////////////
// Chip selects and strobes

assign main_rom_cs = !mreq_n && rom_hit;
assign vram_cs     = !mreq_n && vram_hit;
assign pal_cs      = !mreq_n && pal_hit;
assign misc_we     = mem_wr && misc_hit;
assign flip_we     = mem_wr && flip_hit;  // Tokio only
assign snd_wr      = mem_wr && snd_hit;
assign snd_rd      = mem_rd && snd_hit;

// Source follows any memory cycle so the work RAM sees writes too
always_comb begin
    rd_src = bubl_pkg::SRC_NONE;
    if (!mreq_n) begin
        if (rom_hit)                rd_src = bubl_pkg::SRC_ROM;
        else if (vram_hit)          rd_src = bubl_pkg::SRC_VRAM;
        else if (pal_hit)           rd_src = bubl_pkg::SRC_PAL;
        else if (work_hit)          rd_src = bubl_pkg::SRC_WORK;
        else if (snd_hit)           rd_src = bubl_pkg::SRC_SOUND;
        else if (cab_hit && mem_rd) rd_src = bubl_pkg::SRC_CAB;
    end
end

// Regions of both maps never overlap
always_comb begin
    if (!$isunknown({cpu_addr, mreq_n, rd_n, wr_n, tokio})) begin
        assert ($onehot0({main_rom_cs, vram_cs, pal_cs, misc_we, flip_we,
                          snd_wr | snd_rd, rd_src == bubl_pkg::SRC_WORK,
                          rd_src == bubl_pkg::SRC_CAB}))
            else $error("decode overlap at %h", cpu_addr);
    end
end

endmodule

`default_nettype wire

// File: hdl/bubl_main_ctrl.sv
// Miscellaneous control register and banked main ROM address map
`timescale 1ns/1ps
`default_nettype none
`include "bubl_consts.svh"

module bubl_main_ctrl (
    input  wire                     clk24,
    input  wire                     rst,
    input  wire                     tokio,
    input  wire [`BUBL_AW-1:0]      cpu_addr,
    input  wire [`BUBL_DW-1:0]      cpu_dout,
    input  wire                     misc_we,
    input  wire                     flip_we,
    output logic [`BUBL_ROM_AW-1:0] main_rom_addr,
    output logic                    black_n,
    output logic                    flip,
    output logic                    sub_rst_n,
    output logic                    mcu_rst
);

bubl_pkg::bank_t bank;
logic [3:0]      page;      // 16 KB page in ROM space
logic            flip_load;

// Flip lives at its own address on Tokio
assign flip_load = tokio ? flip_we : misc_we;

////////////////////////////////////////////////////////////
// Control register

always_ff @(posedge clk24 or posedge rst) begin
    if (rst) begin
        bank      <= '0;
        black_n   <= 1'b0;
        flip      <= 1'b0;
        sub_rst_n <= 1'b0;  // Sub CPU held until software releases it
        mcu_rst   <= 1'b1;
    end else begin
        if (misc_we) begin
            if (tokio) begin
                bank      <= cpu_dout[2:0];
                sub_rst_n <= 1'b1;
                mcu_rst   <= 1'b1;  // No MCU on Tokio
            end else begin
                bank      <= cpu_dout[2:0] ^ 3'(`BUBL_BUBBLE_BANK_XOR);
                sub_rst_n <= cpu_dout[4];
                mcu_rst   <= ~cpu_dout[5];
            end
            black_n <= cpu_dout[6];
        end
        if (flip_load) begin
            flip <= cpu_dout[7];
        end
    end
end

////////////////////////////////////////////////////////////
// ROM address map

// Pages 0 and 1 fixed, banked window starts at page 2
assign page = {1'b0, bank} + 4'(`BUBL_BANK_BASE);

always_comb begin
    if (cpu_addr[15]) begin
        main_rom_addr = {page, cpu_addr[13:0]};    // 8000-BFFF banked
    end else begin
        main_rom_addr = {{(`BUBL_ROM_AW-15){1'b0}}, cpu_addr[14:0]};
    end
end

endmodule

`default_nettype wire

// File: hdl/bubl_sound_comm.sv
// Sound CPU latch, strobe, reset and two-way flag handling
`timescale 1ns/1ps
`default_nettype none
`include "bubl_consts.svh"

module bubl_sound_comm (
    input  wire                  clk24,
    input  wire                  rst,
    input  wire [1:0]            cpu_addr,      // Offset within sound window
    input  wire [`BUBL_DW-1:0]   cpu_dout,
    input  wire                  snd_wr,
    input  wire                  snd_rd,
    input  wire                  main_stb,
    input  wire                  snd_flag,
    input  wire [`BUBL_DW-1:0]   main_latch,
    output logic [`BUBL_DW-1:0]  snd_latch,
    output logic                 snd_stb,
    output logic                 snd_rstn,
    output logic                 main_flag,
    output logic [`BUBL_DW-1:0]  snd_rd_data
);

logic snd_wr_q;     // Previous cycle write, for pulse start
logic main_stb_q;

////////////////////////////////////////////////////////////
// Main to sound direction

always_ff @(posedge clk24 or posedge rst) begin
    if (rst) begin
        snd_latch <= '0;
        snd_stb   <= 1'b0;
        snd_rstn  <= 1'b1;  // Sound CPU runs out of reset
        snd_wr_q  <= 1'b0;
    end else begin
        snd_wr_q <= snd_wr;
        snd_stb  <= snd_wr && !snd_wr_q && cpu_addr == 2'd0;
        if (snd_wr) begin
            case (cpu_addr)
                2'd0:    snd_latch <= cpu_dout;
                2'd3:    snd_rstn  <= ~cpu_dout[0];
                default: ;
            endcase
        end
    end
end

////////////////////////////////////////////////////////////
// Sound to main direction

// Flag drops on any read, rises with the sound side strobe
always_ff @(posedge clk24 or posedge rst) begin
    if (rst) begin
        main_flag  <= 1'b1;
        main_stb_q <= 1'b0;
    end else begin
        main_stb_q <= main_stb;
        if (snd_rd) begin
            main_flag <= 1'b0;
        end else if (main_stb && !main_stb_q) begin
            main_flag <= 1'b1;
        end
    end
end

assign snd_rd_data = cpu_addr[0] ? {6'h3f, main_flag, snd_flag} : main_latch;

// One pulse per latch write even if the CPU holds the strobe
assert property (@(posedge clk24) disable iff (rst) snd_stb |=> !snd_stb)
    else $error("snd_stb high for two cycles");

endmodule

`default_nettype wire

// File: hdl/bubl_main_rdmux.sv
// Main work RAM, Tokio cabinet port and two-stage read-data pipeline
`timescale 1ns/1ps
`default_nettype none
`include "bubl_consts.svh"

module bubl_main_rdmux (
    input  wire                     clk24,
    input  wire                     rst,
    input  wire                     tokio,
    input  wire [`BUBL_WORK_AW-1:0] cpu_addr,
    input  wire [`BUBL_DW-1:0]      cpu_dout,
    input  wire bubl_pkg::rd_src_t  rd_src,
    input  wire                     mreq_n,
    input  wire                     wr_n,
    input  wire [`BUBL_DW-1:0]      main_rom_data,
    input  wire [`BUBL_DW-1:0]      vram_dout,
    input  wire [`BUBL_DW-1:0]      pal_dout,
    input  wire [`BUBL_DW-1:0]      snd_rd_data,
    input  wire [1:0]               start_button,
    input  wire [1:0]               coin_input,
    input  wire [5:0]               joystick1,
    input  wire [5:0]               joystick2,
    input  wire [7:0]               dipsw_a,
    input  wire [7:0]               dipsw_b,
    output logic [`BUBL_DW-1:0]     cpu_din
);

logic [`BUBL_DW-1:0] work_mem [0:(1 << `BUBL_WORK_AW)-1];
logic                work_we;
logic [`BUBL_DW-1:0] work_q;
logic [`BUBL_DW-1:0] cab_byte;
logic [`BUBL_DW-1:0] ext_byte;
logic [`BUBL_DW-1:0] ext_q;
bubl_pkg::rd_src_t   src_q;

////////////////////////////////////////////////////////////
// Work RAM

assign work_we = !mreq_n && !wr_n && rd_src == bubl_pkg::SRC_WORK;

always_ff @(posedge clk24) begin
    if (work_we) begin
        work_mem[cpu_addr] <= cpu_dout;
    end
    work_q <= work_mem[cpu_addr];   // Old data on a write cycle
end

////////////////////////////////////////////////////////////
// Tokio cabinet port

always_comb begin
    cab_byte = `BUBL_IDLE_BYTE;
    if (tokio) begin
        case (cpu_addr[2:0])
            3'd3: cab_byte = dipsw_a;
            3'd4: cab_byte = dipsw_b;
            3'd5: cab_byte = {2'b11, 2'b11, coin_input, 2'b11};
            3'd6: cab_byte = {1'b1, start_button[0], joystick1[4], joystick1[5],
                              joystick1[3:2], joystick1[0], joystick1[1]};
            3'd7: cab_byte = {1'b1, start_button[1], joystick2[4], joystick2[5],
                              joystick2[3:2], joystick2[0], joystick2[1]};
            default: cab_byte = `BUBL_IDLE_BYTE;
        endcase
    end
end

// Everything except the work RAM merges before stage 1
always_comb begin
    case (rd_src)
        bubl_pkg::SRC_ROM:   ext_byte = main_rom_data;
        bubl_pkg::SRC_VRAM:  ext_byte = vram_dout;
        bubl_pkg::SRC_PAL:   ext_byte = pal_dout;
        bubl_pkg::SRC_SOUND: ext_byte = snd_rd_data;
        bubl_pkg::SRC_CAB:   ext_byte = cab_byte;
        default:             ext_byte = `BUBL_IDLE_BYTE;
    endcase
end

////////////////////////////////////////////////////////////
// Read pipeline

// Stage 1 alongside the RAM read
always_ff @(posedge clk24 or posedge rst) begin
    if (rst) begin
        src_q <= bubl_pkg::SRC_NONE;
    end else begin
        src_q <= rd_src;
    end
end

always_ff @(posedge clk24) begin
    ext_q <= ext_byte;
end

// Stage 2 output register
always_ff @(posedge clk24) begin
    cpu_din <= (src_q == bubl_pkg::SRC_WORK) ? work_q : ext_q;
end

endmodule

`default_nettype wire

// File: hdl/bubl_main_bus.sv
// Top level of the main CPU bus glue: decoder, control, sound and read mux
`timescale 1ns/1ps
`default_nettype none
`include "bubl_consts.svh"

module bubl_main_bus (
    input  wire                     clk24,
    input  wire                     rst,
    input  wire                     tokio,      // Game select
    // CPU bus
    input  wire [`BUBL_AW-1:0]      cpu_addr,
    input  wire [`BUBL_DW-1:0]      cpu_dout,
    input  wire                     mreq_n,
    input  wire                     rd_n,
    input  wire                     wr_n,
    output logic [`BUBL_DW-1:0]     cpu_din,
    // Video and ROM
    output logic                    vram_cs,
    output logic                    pal_cs,
    output logic                    main_rom_cs,
    output logic [`BUBL_ROM_AW-1:0] main_rom_addr,
    input  wire [`BUBL_DW-1:0]      main_rom_data,
    input  wire [`BUBL_DW-1:0]      vram_dout,
    input  wire [`BUBL_DW-1:0]      pal_dout,
    output logic                    black_n,
    output logic                    flip,
    output logic                    sub_rst_n,
    output logic                    mcu_rst,
    // Sound CPU
    input  wire [`BUBL_DW-1:0]      main_latch,
    input  wire                     snd_flag,
    input  wire                     main_stb,
    output logic [`BUBL_DW-1:0]     snd_latch,
    output logic                    snd_stb,
    output logic                    snd_rstn,
    output logic                    main_flag,
    // Cabinet
    input  wire [1:0]               start_button,
    input  wire [1:0]               coin_input,
    input  wire [5:0]               joystick1,
    input  wire [5:0]               joystick2,
    input  wire [7:0]               dipsw_a,
    input  wire [7:0]               dipsw_b
);

bubl_pkg::rd_src_t   rd_src;
logic                misc_we, flip_we;
logic                snd_wr, snd_rd;
logic [`BUBL_DW-1:0] snd_rd_data;

bubl_main_decode u_decode (
    .tokio       ( tokio       ),
    .cpu_addr    ( cpu_addr    ),
    .mreq_n      ( mreq_n      ),
    .rd_n        ( rd_n        ),
    .wr_n        ( wr_n        ),
    .rd_src      ( rd_src      ),
    .vram_cs     ( vram_cs     ),
    .pal_cs      ( pal_cs      ),
    .main_rom_cs ( main_rom_cs ),
    .misc_we     ( misc_we     ),
    .flip_we     ( flip_we     ),
    .snd_wr      ( snd_wr      ),
    .snd_rd      ( snd_rd      )
);

bubl_main_ctrl u_ctrl (
    .clk24         ( clk24         ),
    .rst           ( rst           ),
    .tokio         ( tokio         ),
    .cpu_addr      ( cpu_addr      ),
    .cpu_dout      ( cpu_dout      ),
    .misc_we       ( misc_we       ),
    .flip_we       ( flip_we       ),
    .main_rom_addr ( main_rom_addr ),
    .black_n       ( black_n       ),
    .flip          ( flip          ),
    .sub_rst_n     ( sub_rst_n     ),
    .mcu_rst       ( mcu_rst       )
);

bubl_sound_comm u_sound (
    .clk24       ( clk24         ),
    .rst         ( rst           ),
    .cpu_addr    ( cpu_addr[1:0] ),
    .cpu_dout    ( cpu_dout      ),
    .snd_wr      ( snd_wr        ),
    .snd_rd      ( snd_rd        ),
    .main_stb    ( main_stb      ),
    .snd_flag    ( snd_flag      ),
    .main_latch  ( main_latch    ),
    .snd_latch   ( snd_latch     ),
    .snd_stb     ( snd_stb       ),
    .snd_rstn    ( snd_rstn      ),
    .main_flag   ( main_flag     ),
    .snd_rd_data ( snd_rd_data   )
);

bubl_main_rdmux u_rdmux (
    .clk24         ( clk24                       ),
    .rst           ( rst                         ),
    .tokio         ( tokio                       ),
    .cpu_addr      ( cpu_addr[`BUBL_WORK_AW-1:0] ),
    .cpu_dout      ( cpu_dout                    ),
    .rd_src        ( rd_src                      ),
    .mreq_n        ( mreq_n                      ),
    .wr_n          ( wr_n                        ),
    .main_rom_data ( main_rom_data               ),
    .vram_dout     ( vram_dout                   ),
    .pal_dout      ( pal_dout                    ),
    .snd_rd_data   ( snd_rd_data                 ),
    .start_button  ( start_button                ),
    .coin_input    ( coin_input                  ),
    .joystick1     ( joystick1                   ),
    .joystick2     ( joystick2                   ),
    .dipsw_a       ( dipsw_a                     ),
    .dipsw_b       ( dipsw_b                     ),
    .cpu_din       ( cpu_din                     )
);

endmodule

`default_nettype wire

// File: dv/tb_bubl_main.sv
// Directed testbench for the main CPU bus glue with bus tasks, compare tasks and timeout
`timescale 1ns/1ps
`default_nettype none
`include "bubl_consts.svh"

module tb_bubl_main;

localparam int NUM_TESTS       = 6;
localparam int CYCLES_PER_TEST = 150;   // Longest test needs about 100
localparam int CYCLE_LIMIT     = NUM_TESTS * CYCLES_PER_TEST + 10;
localparam int WORK_N          = 8;

logic                     clk24 = 1'b0;
logic                     rst, tokio;
logic [`BUBL_AW-1:0]      cpu_addr;
logic [`BUBL_DW-1:0]      cpu_dout, cpu_din;
logic                     mreq_n, rd_n, wr_n;
logic                     vram_cs, pal_cs, main_rom_cs;
logic [`BUBL_ROM_AW-1:0]  main_rom_addr;
logic [`BUBL_DW-1:0]      main_rom_data, vram_dout, pal_dout;
logic                     black_n, flip, sub_rst_n, mcu_rst;
logic [`BUBL_DW-1:0]      main_latch, snd_latch;
logic                     snd_flag, main_stb, snd_stb, snd_rstn, main_flag;
logic [1:0]               start_button, coin_input;
logic [5:0]               joystick1, joystick2;
logic [7:0]               dipsw_a, dipsw_b;
logic [`BUBL_AW-1:0]      work_addr [WORK_N];
logic [`BUBL_DW-1:0]      work_data [WORK_N];
int                       errors = 0;
int                       checks = 0;
int                       cycle_count = 0;

bubl_main_bus uut (.*);

always #5 clk24 = ~clk24;

always @(posedge clk24) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
        $display("Timeout after %0d cycles, tests did not finish", CYCLE_LIMIT);
        $display("Regression failed");
        $finish;
    end
end

//////////////////////////////////////////////////////////////
// Compare tasks and reference models

task automatic check_byte(input string name, input logic [`BUBL_DW-1:0] got, exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
endtask

task automatic check_bit(input string name, input logic got, exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
endtask

task automatic check_rom_addr(input string name, input logic [`BUBL_ROM_AW-1:0] got, exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
endtask

task automatic check_bank(input string name, input bubl_pkg::bank_t got, exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
endtask

// Upper window maps to 16 KB page bank+2, lower 32 KB straight through
function automatic logic [`BUBL_ROM_AW-1:0] rom_addr_model(input logic [15:0] a,
                                                          input bubl_pkg::bank_t b);
    int r;
    if (a >= 16'h8000)
        r = (int'(b) + `BUBL_BANK_BASE) * 32'h4000 + (int'(a) - 32'h8000);
    else
        r = int'(a);
    rom_addr_model = r[`BUBL_ROM_AW-1:0];
endfunction

function automatic logic [7:0] joy_byte(input logic start, input logic [5:0] joy);
    return {1'b1, start, joy[4], joy[5], joy[3], joy[2], joy[0], joy[1]};
endfunction

function automatic logic [7:0] cab_model(input logic [2:0] off);
    case (off)
        3'd3:    return dipsw_a;
        3'd4:    return dipsw_b;
        3'd5:    return {4'hF, coin_input, 2'b11};
        3'd6:    return joy_byte(start_button[0], joystick1);
        3'd7:    return joy_byte(start_button[1], joystick2);
        default: return `BUBL_IDLE_BYTE;
    endcase
endfunction

// Chip selects follow the address ranges shared by both maps
task automatic check_selects(input logic [15:0] addr);
    check_bit("main_rom_cs", main_rom_cs, addr < 16'hC000);
    check_bit("vram_cs", vram_cs, addr >= 16'hC000 && addr < 16'hE000);
    check_bit("pal_cs", pal_cs, addr >= 16'hF800 && addr < 16'hFA00);
endtask

//////////////////////////////////////////////////////////////
// Bus tasks

task automatic set_game(input logic g);
    @(posedge clk24);
    tokio <= g;
endtask

task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
    @(posedge clk24);
    cpu_addr <= addr;
    cpu_dout <= data;
    mreq_n   <= 1'b0;
    wr_n     <= 1'b0;
    @(posedge clk24);       // Write taken here
    mreq_n <= 1'b1;
    wr_n   <= 1'b1;
endtask

task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
    @(posedge clk24);
    cpu_addr <= addr;
    mreq_n   <= 1'b0;
    rd_n     <= 1'b0;
    @(negedge clk24);
    check_selects(addr);
    @(posedge clk24);       // Stage 1
    mreq_n <= 1'b1;
    rd_n   <= 1'b1;
    @(posedge clk24);       // Output register loads
    @(negedge clk24);
    data = cpu_din;
endtask

task automatic read_compare(input logic [15:0] addr, input logic [7:0] exp, input string name);
    logic [7:0] got;
    bus_read(addr, got);
    check_byte(name, got, exp);
endtask

// Control outputs, then the ROM map above and below 8000
task automatic check_ctrl(input bubl_pkg::bank_t bank_exp, input logic blk, flp, sub, mcu);
    logic [15:0] hi;
    logic [15:0] lo;
    hi = 16'h8000 | 16'($urandom % 32'h4000);
    lo = 16'($urandom % 32'h8000);
    @(negedge clk24);
    check_bit("black_n", black_n, blk);
    check_bit("flip", flip, flp);
    check_bit("sub_rst_n", sub_rst_n, sub);
    check_bit("mcu_rst", mcu_rst, mcu);
    @(posedge clk24);
    cpu_addr <= hi;
    @(negedge clk24);
    check_rom_addr("main_rom_addr", main_rom_addr, rom_addr_model(hi, bank_exp));
    check_bank("bank", 3'(main_rom_addr[17:14] - 4'(`BUBL_BANK_BASE)), bank_exp);
    @(posedge clk24);
    cpu_addr <= lo;
    @(negedge clk24);
    check_rom_addr("main_rom_addr", main_rom_addr, rom_addr_model(lo, bank_exp));
endtask

task automatic pulse_main_stb;
    @(posedge clk24);
    main_stb <= 1'b1;
    @(posedge clk24);
    main_stb <= 1'b0;
    @(negedge clk24);
endtask

//////////////////////////////////////////////////////////////
// Tests

task automatic test_reset_values;
    check_ctrl(3'd0, 1'b0, 1'b0, 1'b0, 1'b1);
    check_bit("snd_stb", snd_stb, 1'b0);
    check_bit("snd_rstn", snd_rstn, 1'b1);
    check_byte("snd_latch", snd_latch, 8'h00);
    check_bit("main_flag", main_flag, 1'b1);
endtask

task automatic test_work_ram;
    set_game(1'b0);
    for (int i = 0; i < WORK_N; i++) begin
        work_addr[i] = 16'hE000 + 16'(i * 704) + 16'($urandom % 64);    // Distinct slots
        work_data[i] = 8'($urandom);
        bus_write(work_addr[i], work_data[i]);
    end
    for (int i = 0; i < WORK_N; i++)
        read_compare(work_addr[i], work_data[i], "cpu_din work RAM");
    @(posedge clk24);
    main_rom_data <= 8'($urandom);
    vram_dout     <= 8'($urandom);
    pal_dout      <= 8'($urandom);
    @(negedge clk24);
    read_compare(16'h3A5C, main_rom_data, "cpu_din ROM");
    read_compare(16'hC9A0, vram_dout, "cpu_din VRAM");
    read_compare(16'hF8F1, pal_dout, "cpu_din palette");
    read_compare(16'hFB10, `BUBL_IDLE_BYTE, "cpu_din undecoded");
    read_compare(16'hFC20, `BUBL_IDLE_BYTE, "cpu_din undecoded");
    read_compare(16'hFF00, `BUBL_IDLE_BYTE, "cpu_din undecoded");
    set_game(1'b1);
    // Reads every cycle, data trails the address by two
    for (int k = 0; k < WORK_N + 2; k++) begin
        @(posedge clk24);
        if (k < WORK_N) begin
            cpu_addr <= work_addr[k];
            mreq_n   <= 1'b0;
            rd_n     <= 1'b0;
        end else begin
            mreq_n <= 1'b1;
            rd_n   <= 1'b1;
        end
        @(negedge clk24);
        if (k >= 2)
            check_byte("cpu_din work RAM burst", cpu_din, work_data[k-2]);
    end
    read_compare(16'hFD00, `BUBL_IDLE_BYTE, "cpu_din undecoded");
    read_compare(16'hFB40, `BUBL_IDLE_BYTE, "cpu_din undecoded");
    read_compare(16'hFE80, `BUBL_IDLE_BYTE, "cpu_din undecoded");
endtask

task automatic test_misc;
    logic [7:0] d;
    logic       e_flip;
    set_game(1'b0);
    for (int i = 0; i < 3; i++) begin
        d = (i == 0) ? 8'hD3 : (i == 1) ? 8'h25 : 8'($urandom);
        bus_write(16'hFB40, d);
        check_ctrl({~d[2], d[1:0]}, d[6], d[7], d[4], ~d[5]);
    end
    e_flip = d[7];
    set_game(1'b1);
    for (int i = 0; i < 3; i++) begin
        d = 8'($urandom);
        bus_write(16'hFA80, d);
        check_ctrl(d[2:0], d[6], e_flip, 1'b1, 1'b1);  // Flip has its own address
        bus_write(16'hFB00, ~d);
        e_flip = ~d[7];
        check_ctrl(d[2:0], d[6], e_flip, 1'b1, 1'b1);
    end
endtask

task automatic test_sound;
    logic [7:0] d;
    logic [7:0] ml;
    d  = 8'($urandom);
    ml = 8'($urandom);
    set_game(1'b0);
    bus_write(16'hFA00, d);
    @(negedge clk24);
    check_byte("snd_latch", snd_latch, d);
    check_bit("snd_stb", snd_stb, 1'b1);
    @(negedge clk24);
    check_bit("snd_stb", snd_stb, 1'b0);
    bus_write(16'hFA03, 8'h01);
    @(negedge clk24);
    check_bit("snd_rstn", snd_rstn, 1'b0);
    bus_write(16'hFA03, 8'hFE);
    @(negedge clk24);
    check_bit("snd_rstn", snd_rstn, 1'b1);
    @(posedge clk24);
    main_latch <= ml;
    read_compare(16'hFA00, ml, "cpu_din sound latch");
    set_game(1'b1);
    bus_write(16'hFC00, ~d);    // Tokio sound window
    @(negedge clk24);
    check_byte("snd_latch", snd_latch, ~d);
    check_bit("snd_stb", snd_stb, 1'b1);
endtask

task automatic test_flags;
    set_game(1'b0);
    pulse_main_stb;
    check_bit("main_flag", main_flag, 1'b1);
    @(posedge clk24);
    snd_flag <= 1'b0;
    read_compare(16'hFA01, {6'h3f, 1'b1, 1'b0}, "cpu_din sound flags");
    check_bit("main_flag", main_flag, 1'b0);
    @(posedge clk24);
    snd_flag <= 1'b1;
    read_compare(16'hFA01, {6'h3f, 1'b0, 1'b1}, "cpu_din sound flags");
    pulse_main_stb;
    check_bit("main_flag", main_flag, 1'b1);
endtask

task automatic test_cabinet;
    set_game(1'b1);
    for (int r = 0; r < 2; r++) begin
        @(posedge clk24);
        dipsw_a      <= 8'($urandom);
        dipsw_b      <= 8'($urandom);
        coin_input   <= 2'($urandom);
        start_button <= 2'($urandom);
        joystick1    <= 6'($urandom);
        joystick2    <= 6'($urandom);
        @(negedge clk24);
        for (int off = 0; off < 8; off++)
            read_compare(16'hFA00 + 16'(off), cab_model(3'(off)), "cpu_din cabinet");
    end
endtask

initial begin
    void'($urandom(32'h20f312ef));
    rst           <= 1'b1;
    tokio         <= 1'b0;
    cpu_addr      <= '0;
    cpu_dout      <= '0;
    mreq_n        <= 1'b1;
    rd_n          <= 1'b1;
    wr_n          <= 1'b1;
    main_rom_data <= '0;
    vram_dout     <= '0;
    pal_dout      <= '0;
    main_latch    <= '0;
    snd_flag      <= 1'b0;
    main_stb      <= 1'b0;
    start_button  <= 2'b11;     // Inputs idle high
    coin_input    <= 2'b11;
    joystick1     <= '1;
    joystick2     <= '1;
    dipsw_a       <= '1;
    dipsw_b       <= '1;
    repeat (5) @(posedge clk24);
    rst <= 1'b0;
    test_reset_values;
    test_work_ram;
    test_misc;
    test_sound;
    test_flags;
    test_cabinet;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
        $display("Regression passed");
    else
        $display("Regression failed");
    $finish;
end

endmodule

`default_nettype wire

// File: compile.f
+incdir+hdl
hdl/bubl_pkg.sv
hdl/bubl_main_decode.sv
hdl/bubl_main_ctrl.sv
hdl/bubl_sound_comm.sv
hdl/bubl_main_rdmux.sv
hdl/bubl_main_bus.sv
dv/tb_bubl_main.sv

// File: Makefile
# Verilator build and run, lint and clean for the main CPU bus glue
TOP  := tb_bubl_main
SRCS := $(filter-out +%,$(shell cat compile.f)) hdl/bubl_consts.svh

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): compile.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f \
		--top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Regression passed" sim.log

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f compile.f \
		--top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
